//--- hw/perf_pkg.sv
// Retire-trace performance monitor shared widths, constants and counter indices
package perf_pkg;

    //////////////////////////////////////////////////
    // Trace and bus widths

    localparam int RETIRE_PORTS = 2;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] stat_count_t;
    typedef logic [4:0] opcode_t;

    // Wide enough to hold a match on every retire port
    typedef logic [$clog2(RETIRE_PORTS + 1)-1:0] mix_inc_t;

    //////////////////////////////////////////////////
    // Benchmark markers and simulated UART

    // addi x0, x0, 12 and addi x0, x0, 13
    localparam instr_t START_MARKER = 32'h00C00013;
    localparam instr_t END_MARKER = 32'h00D00013;

    localparam addr_t UART_ADDR = 32'h88001000;

    //////////////////////////////////////////////////
    // Opcode classes on instruction bits 6 to 2

    localparam opcode_t ARITH = 5'b01100;
    localparam opcode_t ARITH_IMM = 5'b00100;
    localparam opcode_t AUIPC = 5'b00101;
    localparam opcode_t LUI = 5'b01101;
    localparam opcode_t BRANCH = 5'b11000;
    localparam opcode_t JAL = 5'b11011;
    localparam opcode_t JALR = 5'b11001;
    localparam opcode_t LOAD = 5'b00000;
    localparam opcode_t AMO = 5'b01011;
    localparam opcode_t STORE = 5'b01000;
    localparam opcode_t SYSTEM = 5'b11100;
    localparam opcode_t FENCE = 5'b00011;

    //////////////////////////////////////////////////
    // Counter indices

    typedef enum logic [3:0] {
        // Instruction mix
        ALU_STAT,
        BR_STAT,
        MUL_STAT,
        DIV_STAT,
        LOAD_STAT,
        STORE_STAT,
        MISC_STAT,
        RETIRE_STAT,
        // Issue stage stalls
        ISSUE_NO_INSTRUCTION_STAT,
        ISSUE_NO_ID_STAT,
        ISSUE_FLUSH_STAT,
        ISSUE_UNIT_BUSY_STAT,
        ISSUE_OPERANDS_STAT,
        ISSUE_HOLD_STAT,
        ISSUE_MULTI_SOURCE_STAT
    } stat_id_e;

    localparam int NUM_STATS = int'(ISSUE_MULTI_SOURCE_STAT) + 1;

    typedef mix_inc_t [NUM_STATS-1:0] stat_inc_t;

endpackage

//--- hw/retire_mix_classifier.sv
// Instruction mix classifier that turns retired opcodes into per-class counter increments
module retire_mix_classifier (
    input logic [perf_pkg::RETIRE_PORTS-1:0] retire_valid,
    input perf_pkg::instr_t [perf_pkg::RETIRE_PORTS-1:0] retire_instruction,
    output perf_pkg::stat_inc_t mix_inc
);
    import perf_pkg::*;

    opcode_t opcode [RETIRE_PORTS];
    logic is_mul [RETIRE_PORTS];
    logic is_div [RETIRE_PORTS];
    logic [NUM_STATS-1:0] port_hit [RETIRE_PORTS];

    //////////////////////////////////////////////////
    // Per-port decode
    always_comb begin
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            opcode[p] = retire_instruction[p][6:2];
            // M extension shares the ARITH opcode with funct7 bit 25 set
            is_mul[p] = retire_instruction[p][25] & ~retire_instruction[p][14];
            is_div[p] = retire_instruction[p][25] & retire_instruction[p][14];

            port_hit[p] = '0;
            port_hit[p][ALU_STAT] = retire_valid[p]
                & (opcode[p] inside {ARITH, ARITH_IMM, AUIPC, LUI})
                & ~(is_mul[p] | is_div[p]);
            port_hit[p][BR_STAT] = retire_valid[p]
                & (opcode[p] inside {BRANCH, JAL, JALR});
            port_hit[p][MUL_STAT] = retire_valid[p] & (opcode[p] == ARITH) & is_mul[p];
            port_hit[p][DIV_STAT] = retire_valid[p] & (opcode[p] == ARITH) & is_div[p];
            // Atomics both read and write memory
            port_hit[p][LOAD_STAT] = retire_valid[p] & (opcode[p] inside {LOAD, AMO});
            port_hit[p][STORE_STAT] = retire_valid[p] & (opcode[p] inside {STORE, AMO});
            port_hit[p][MISC_STAT] = retire_valid[p] & (opcode[p] inside {SYSTEM, FENCE});
            port_hit[p][RETIRE_STAT] = retire_valid[p];
        end
    end

    //////////////////////////////////////////////////
    // Sum matches across ports
    always_comb begin
        mix_inc = '0;
        for (int s = 0; s < NUM_STATS; s++) begin
            for (int p = 0; p < RETIRE_PORTS; p++) begin
                mix_inc[s] = mix_inc[s] + mix_inc_t'(port_hit[p][s]);
            end
        end
    end

    // ALU, MUL and DIV are disjoint subsets of retired instructions
    alu_mul_div_bound: assert final (
        (3'(mix_inc[ALU_STAT]) + 3'(mix_inc[MUL_STAT]) + 3'(mix_inc[DIV_STAT]))
            <= 3'(mix_inc[RETIRE_STAT])
    ) else $error("Mix increments exceed retire increment");

endmodule

//--- hw/issue_stall_classifier.sv
// Issue-stage stall classifier that picks one stall cause or the multi-source bucket
module issue_stall_classifier (
    input logic issue_stage_valid,
    input logic fetch_flush,
    input logic id_exhausted,
    input logic unit_busy,
    input logic operands_not_ready,
    input logic issue_hold,
    output perf_pkg::stat_inc_t stall_inc
);
    import perf_pkg::*;

    logic base_no_instruction;
    logic base_unit_busy;
    logic base_operands;
    logic base_hold;
    logic [2:0] stall_source_count;
    logic single_source;
    logic any_source;

    //////////////////////////////////////////////////
    // Base causes
    always_comb begin
        // A flush empties the issue stage even when it still shows valid
        base_no_instruction = ~issue_stage_valid | fetch_flush;
        base_unit_busy = issue_stage_valid & unit_busy;
        base_operands = issue_stage_valid & operands_not_ready;
        base_hold = issue_stage_valid & issue_hold;

        stall_source_count = 3'(base_no_instruction) + 3'(base_unit_busy)
            + 3'(base_operands) + 3'(base_hold);
        single_source = (stall_source_count == 3'd1);
        any_source = (stall_source_count != 3'd0);
    end

    //////////////////////////////////////////////////
    // Category increments
    always_comb begin
        stall_inc = '0;
        stall_inc[ISSUE_NO_INSTRUCTION_STAT] = mix_inc_t'(base_no_instruction & single_source);
        // Sub-causes of an empty issue stage
        stall_inc[ISSUE_NO_ID_STAT] =
            mix_inc_t'(base_no_instruction & id_exhausted & single_source);
        stall_inc[ISSUE_FLUSH_STAT] =
            mix_inc_t'(base_no_instruction & fetch_flush & single_source);
        stall_inc[ISSUE_UNIT_BUSY_STAT] = mix_inc_t'(base_unit_busy & single_source);
        stall_inc[ISSUE_OPERANDS_STAT] = mix_inc_t'(base_operands & single_source);
        stall_inc[ISSUE_HOLD_STAT] = mix_inc_t'(base_hold & single_source);
        stall_inc[ISSUE_MULTI_SOURCE_STAT] = mix_inc_t'(any_source & ~single_source);
    end

    sub_cause_needs_parent: assert final (
        !((stall_inc[ISSUE_NO_ID_STAT] != '0) || (stall_inc[ISSUE_FLUSH_STAT] != '0))
        || (stall_inc[ISSUE_NO_INSTRUCTION_STAT] != '0)
    ) else $error("No-id or flush counted without no-instruction");

endmodule

//--- hw/collection_window.sv
// Benchmark collection window driven by start and end marker NOPs on the retire trace
module collection_window (
    input logic clk,
    input logic rst_n,
    input logic [perf_pkg::RETIRE_PORTS-1:0] retire_valid,
    input perf_pkg::instr_t [perf_pkg::RETIRE_PORTS-1:0] retire_instruction,
    output logic collecting,
    output logic window_start
);
    import perf_pkg::*;

    logic start_seen;
    logic end_seen;

    // Marker match on any valid port
    always_comb begin
        start_seen = 1'b0;
        end_seen = 1'b0;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            start_seen |= retire_valid[p] & (retire_instruction[p] == START_MARKER);
            end_seen |= retire_valid[p] & (retire_instruction[p] == END_MARKER);
        end
    end

    assign window_start = start_seen;

    // End marker cycle is still inside the window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            collecting <= 1'b0;
        end else if (start_seen) begin
            collecting <= 1'b1;
        end else if (end_seen) begin
            collecting <= 1'b0;
        end
    end

    markers_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(start_seen && end_seen)
    ) else $error("Start and end markers retired together");

endmodule

//--- hw/stat_counter_bank.sv
// Bank of statistic counters with window clear, gated accumulate and a read mux
module stat_counter_bank (
    input logic clk,
    input logic rst_n,
    input logic collecting,
    input logic window_start,
    input perf_pkg::stat_inc_t stat_inc,
    input perf_pkg::stat_id_e stat_sel,
    output perf_pkg::stat_count_t stat_value
);
    import perf_pkg::*;

    stat_count_t counters [NUM_STATS];

    //////////////////////////////////////////////////
    // Accumulate
    // A new start marker restarts the window from zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counters <= '{default: '0};
        end else if (window_start) begin
            counters <= '{default: '0};
        end else if (collecting) begin
            for (int s = 0; s < NUM_STATS; s++) begin
                counters[s] <= counters[s] + stat_count_t'(stat_inc[s]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback
    always_comb begin
        if (int'(stat_sel) < NUM_STATS) begin
            stat_value = counters[stat_sel];
        end else begin
            stat_value = '0;
        end
    end

    sel_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) int'(stat_sel) < NUM_STATS
    ) else $error("stat_sel out of range");

endmodule

//--- hw/uart_write_capture.sv
// Simulated UART capture that strobes out the byte of each AXI write to the UART address
module uart_write_capture (
    input logic clk,
    input logic rst_n,
    input logic bus_wvalid,
    input logic bus_wready,
    input perf_pkg::addr_t bus_awaddr,
    input perf_pkg::instr_t bus_wdata,
    output logic write_uart,
    output logic [7:0] uart_byte
);
    import perf_pkg::*;

    logic uart_hit;

    // Completed write beat aimed at the UART
    assign uart_hit = bus_wvalid & bus_wready & (bus_awaddr == UART_ADDR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_uart <= 1'b0;
        end else begin
            write_uart <= uart_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (uart_hit) begin
            uart_byte <= bus_wdata[7:0];
        end
    end

endmodule

//--- hw/perf_monitor_top.sv
// Retire-trace performance monitor top with instruction mix, stall breakdown and UART capture
module perf_monitor_top (
    input logic clk,
    input logic rst_n,

    // Retire trace
    input logic [perf_pkg::RETIRE_PORTS-1:0] retire_valid,
    input perf_pkg::instr_t [perf_pkg::RETIRE_PORTS-1:0] retire_instruction,

    // Issue stage levels
    input logic issue_stage_valid,
    input logic fetch_flush,
    input logic id_exhausted,
    input logic unit_busy,
    input logic operands_not_ready,
    input logic issue_hold,

    // AXI write channel
    input logic bus_wvalid,
    input logic bus_wready,
    input perf_pkg::addr_t bus_awaddr,
    input perf_pkg::instr_t bus_wdata,

    // Counter readback
    input perf_pkg::stat_id_e stat_sel,
    output perf_pkg::stat_count_t stat_value,
    output logic collecting,

    output logic write_uart,
    output logic [7:0] uart_byte
);
    import perf_pkg::*;

    stat_inc_t mix_inc;
    stat_inc_t stall_inc;
    stat_inc_t stat_inc;
    logic window_start;

    //////////////////////////////////////////////////
    // UART capture
    uart_write_capture uart_i (
        .clk (clk),
        .rst_n (rst_n),
        .bus_wvalid (bus_wvalid),
        .bus_wready (bus_wready),
        .bus_awaddr (bus_awaddr),
        .bus_wdata (bus_wdata),
        .write_uart (write_uart),
        .uart_byte (uart_byte)
    );

    //////////////////////////////////////////////////
    // Marker detection
    collection_window window_i (
        .clk (clk),
        .rst_n (rst_n),
        .retire_valid (retire_valid),
        .retire_instruction (retire_instruction),
        .collecting (collecting),
        .window_start (window_start)
    );

    //////////////////////////////////////////////////
    // Issue stalls and instruction mix
    issue_stall_classifier stall_i (
        .issue_stage_valid (issue_stage_valid),
        .fetch_flush (fetch_flush),
        .id_exhausted (id_exhausted),
        .unit_busy (unit_busy),
        .operands_not_ready (operands_not_ready),
        .issue_hold (issue_hold),
        .stall_inc (stall_inc)
    );

    retire_mix_classifier mix_i (
        .retire_valid (retire_valid),
        .retire_instruction (retire_instruction),
        .mix_inc (mix_inc)
    );

    // Each classifier leaves the other's indices at zero
    assign stat_inc = mix_inc | stall_inc;

    //////////////////////////////////////////////////
    // Statistics
    stat_counter_bank stats_i (
        .clk (clk),
        .rst_n (rst_n),
        .collecting (collecting),
        .window_start (window_start),
        .stat_inc (stat_inc),
        .stat_sel (stat_sel),
        .stat_value (stat_value)
    );

endmodule

//--- include/perf_tb_checks.svh
// Testbench check helpers for the performance monitor with value compare and failure exits
`ifndef PERF_TB_CHECKS_SVH
`define PERF_TB_CHECKS_SVH

// Compare an observed value against the expected one
task automatic check_value(
    input string what,
    input logic [31:0] actual,
    input logic [31:0] expected
);
    if (actual !== expected) begin
        $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        $display("Simulation failed");
        $fatal(1, "Check failed on %s", what);
    end
endtask

// Bounded wait ran out
task automatic fail_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "Timeout on %s", what);
endtask

// Pattern file missing
task automatic fail_file_open(input string path);
    $display("Could not open the pattern file %s at %0t", path, $time);
    $display("Simulation failed");
    $fatal(1, "File open failed for %s", path);
endtask

`endif

//--- tb/perf_monitor_tb.sv
// Pattern-driven testbench for the retire-trace performance monitor
module perf_monitor_tb;
    import perf_pkg::*;

    `include "perf_tb_checks.svh"

    localparam int WAIT_LIMIT = 20;
    localparam string PATTERN_PATH = "tb/perf_patterns.txt";

    logic clk;
    logic rst_n;
    logic [RETIRE_PORTS-1:0] retire_valid;
    instr_t [RETIRE_PORTS-1:0] retire_instruction;
    logic issue_stage_valid;
    logic fetch_flush;
    logic id_exhausted;
    logic unit_busy;
    logic operands_not_ready;
    logic issue_hold;
    logic bus_wvalid;
    logic bus_wready;
    addr_t bus_awaddr;
    instr_t bus_wdata;
    stat_id_e stat_sel;
    stat_count_t stat_value;
    logic collecting;
    logic write_uart;
    logic [7:0] uart_byte;

    perf_monitor_top dut_i (
        .clk (clk),
        .rst_n (rst_n),
        .retire_valid (retire_valid),
        .retire_instruction (retire_instruction),
        .issue_stage_valid (issue_stage_valid),
        .fetch_flush (fetch_flush),
        .id_exhausted (id_exhausted),
        .unit_busy (unit_busy),
        .operands_not_ready (operands_not_ready),
        .issue_hold (issue_hold),
        .bus_wvalid (bus_wvalid),
        .bus_wready (bus_wready),
        .bus_awaddr (bus_awaddr),
        .bus_wdata (bus_wdata),
        .stat_sel (stat_sel),
        .stat_value (stat_value),
        .collecting (collecting),
        .write_uart (write_uart),
        .uart_byte (uart_byte)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers

    // Valid issue stage with no stall cause, so idle cycles count nothing
    task automatic drive_idle();
        retire_valid = '0;
        retire_instruction = '0;
        issue_stage_valid = 1'b1;
        fetch_flush = 1'b0;
        id_exhausted = 1'b0;
        unit_busy = 1'b0;
        operands_not_ready = 1'b0;
        issue_hold = 1'b0;
        bus_wvalid = 1'b0;
        bus_wready = 1'b0;
        bus_awaddr = '0;
        bus_wdata = '0;
    endtask

    task automatic finish_cycle();
        @(posedge clk);
        #1;
        drive_idle();
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = 0;
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic wait_uart_strobe();
        int cycles;
        cycles = 0;
        while (write_uart !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                fail_timeout("write_uart");
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    task automatic fail_bad_command(input string cmd);
        $display("Unknown pattern command %s at %0t", cmd, $time);
        $display("Simulation failed");
        $fatal(1, "Bad pattern command");
    endtask

    //////////////////////////////////////////////////
    // Pattern interpreter
    task automatic run_patterns(input int fd);
        string cmd;
        logic [31:0] field [6];
        int n;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd[0] == "#") begin
                skip_line(fd);
            end else if (cmd == "R") begin
                n = $fscanf(fd, "%h %h %h %h", field[0], field[1], field[2], field[3]);
                check_value("R field count", n, 4);
                retire_valid[0] = field[0][0];
                retire_instruction[0] = field[1];
                retire_valid[1] = field[2][0];
                retire_instruction[1] = field[3];
                finish_cycle();
            end else if (cmd == "S") begin
                n = $fscanf(fd, "%h %h %h %h %h %h", field[0], field[1], field[2],
                    field[3], field[4], field[5]);
                check_value("S field count", n, 6);
                issue_stage_valid = field[0][0];
                fetch_flush = field[1][0];
                id_exhausted = field[2][0];
                unit_busy = field[3][0];
                operands_not_ready = field[4][0];
                issue_hold = field[5][0];
                finish_cycle();
            end else if (cmd == "U") begin
                n = $fscanf(fd, "%h %h %h %h", field[0], field[1], field[2], field[3]);
                check_value("U field count", n, 4);
                bus_wvalid = field[0][0];
                bus_wready = field[1][0];
                bus_awaddr = field[2];
                bus_wdata = field[3];
                finish_cycle();
            end else if (cmd == "I") begin
                finish_cycle();
            end else if (cmd == "C") begin
                n = $fscanf(fd, "%d %d", field[0], field[1]);
                check_value("C field count", n, 2);
                stat_sel = stat_id_e'(field[0][3:0]);
                // Readback is combinational, sample mid-cycle
                @(negedge clk);
                check_value($sformatf("counter %0d", field[0]), stat_value, field[1]);
                finish_cycle();
            end else if (cmd == "G") begin
                n = $fscanf(fd, "%h", field[0]);
                check_value("G field count", n, 1);
                check_value("collecting", collecting, field[0]);
            end else if (cmd == "W") begin
                n = $fscanf(fd, "%h %h", field[0], field[1]);
                check_value("W field count", n, 2);
                if (field[0][0]) begin
                    wait_uart_strobe();
                    check_value("uart_byte", uart_byte, field[1]);
                end else begin
                    check_value("write_uart", write_uart, 0);
                end
            end else begin
                fail_bad_command(cmd);
            end
        end
    endtask

    initial begin
        int fd;
        drive_idle();
        stat_sel = ALU_STAT;
        rst_n = 1'b0;
        fd = $fopen(PATTERN_PATH, "r");
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (fd == 0) begin
            fail_file_open(PATTERN_PATH);
        end else begin
            run_patterns(fd);
            $fclose(fd);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- tb/perf_patterns.txt
# R v0 instr0 v1 instr1 | S valid flush no_id busy operands hold | U wvalid wready addr data
# I idle | C sel expected (decimal) | G collecting | W strobe byte ; other fields hex
G 0
R 1 003100B3 1 00012083   # outside any window
I
C 7 0
R 1 00C00013 0 00000000   # start marker
G 1
R 1 003100B3 1 023100B3   # ADD and MUL
R 1 023140B3 0 00000000   # DIV
R 1 00012083 1 00112023   # LW and SW
R 1 00208063 1 00000073   # BEQ and ECALL
R 1 0031202F 1 003100B3   # AMO and ADD
R 0 00000000 1 00D00013   # end marker counts as ALU
G 0
R 1 003100B3 1 00000013   # after the window
C 0 3
C 1 1
C 2 1
C 3 1
C 4 2
C 5 2
C 6 1
C 7 10
C 14 0
R 0 00000000 1 00C00013   # restart on port 1 clears
C 0 0
C 7 0
S 0 0 0 0 0 0
S 0 0 1 0 0 0
S 1 1 0 0 0 0
S 1 0 0 1 0 0
S 1 0 0 0 1 0
S 1 0 0 0 0 1
S 0 0 0 1 0 0             # busy needs a valid issue stage
S 1 0 0 1 1 0
S 1 1 0 0 0 1
C 8 4
C 9 1
C 10 1
C 11 1
C 12 1
C 13 1
C 14 2
C 7 0
U 1 1 88001000 12345641
W 1 41
U 1 1 88001004 000000FF   # wrong address
W 0 00
U 1 0 88001000 000000EE   # wready low
W 0 00
U 1 1 88001000 0000005A
W 1 5A

//--- sim.f
+incdir+include
hw/perf_pkg.sv
hw/retire_mix_classifier.sv
hw/issue_stall_classifier.sv
hw/collection_window.sv
hw/stat_counter_bank.sv
hw/uart_write_capture.sv
hw/perf_monitor_top.sv
tb/perf_monitor_tb.sv

//--- Bender.yml
package:
  name: perf_monitor

sources:
  - files:
      - hw/perf_pkg.sv
      - hw/retire_mix_classifier.sv
      - hw/issue_stall_classifier.sv
      - hw/collection_window.sv
      - hw/stat_counter_bank.sv
      - hw/uart_write_capture.sv
      - hw/perf_monitor_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/perf_monitor_tb.sv
